//--- Makefile
# Verilator build, run, lint and clean for the mcm testbench

.PHONY: all lint clean

# build, run, and pass only if the testbench printed its pass line
all: obj_dir/Vmcm_tb
	@out="$$(./obj_dir/Vmcm_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

obj_dir/Vmcm_tb: build.f $(wildcard logic/*.sv sim/*.sv)
	verilator --binary --timing --assert --top-module mcm_tb -f build.f -o Vmcm_tb

lint:
	verilator --lint-only -Wall --timing --assert --top-module mcm_tb -f build.f

clean:
	rm -rf obj_dir

//--- build.f
logic/mcm_pkg.sv
logic/mcm_base_terms.sv
logic/mcm_coeff_bank.sv
logic/mcm_top.sv
sim/tb_clock.sv
sim/mcm_properties.sv
sim/mcm_tb.sv

//--- logic/mcm_base_terms.sv
// Shared partial product stage
`timescale 1ns/100ps
`default_nettype none

module mcm_base_terms #(
	parameter int DATA_W = 17,
	parameter int PROD_W = 25
) (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic signed [DATA_W-1:0] i_data,
	input  wire logic                     i_vld_r16,
	input  wire logic                     i_vld_r8,
	input  wire logic                     i_vld_r4,
	input  wire logic                     i_vld_a4,
	input  wire logic                     i_vld_dst,
	output logic signed [PROD_W-1:0]      o_term_x1,
	output logic signed [PROD_W-1:0]      o_term_x9,
	output logic signed [PROD_W-1:0]      o_term_x11,
	output logic signed [PROD_W-1:0]      o_term_x13,
	output logic [4:0]                    o_term_vld
);

	// sample at product width
	logic signed [PROD_W-1:0] x1;
	logic signed [PROD_W-1:0] x9;
	logic signed [PROD_W-1:0] x11;
	logic signed [PROD_W-1:0] x13;

	// replicate the sign bit up to product width
	assign x1 = {{(PROD_W-DATA_W){i_data[DATA_W-1]}}, i_data};

	// 9x = 8x + x
	assign x9 = (x1 <<< 3) + x1;
	// 11x = 9x + 2x
	assign x11 = x9 + (x1 <<< 1);
	// 13x = 9x + 4x
	assign x13 = x9 + (x1 <<< 2);

	// pipeline register between the stages
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			o_term_x1  <= '0;
			o_term_x9  <= '0;
			o_term_x11 <= '0;
			o_term_x13 <= '0;
		end
		else
		begin
			// terms load every cycle, the valids qualify them downstream
			o_term_x1  <= x1;
			o_term_x9  <= x9;
			o_term_x11 <= x11;
			o_term_x13 <= x13;
		end
	end

	// group valids travel with the terms
	// bit order r16 r8 r4 a4 dst from bit 0 up
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_term_vld <= '0;
		else
			o_term_vld <= {i_vld_dst, i_vld_a4, i_vld_r4, i_vld_r8, i_vld_r16};
	end

endmodule

`default_nettype wire

//--- logic/mcm_coeff_bank.sv
// Coefficient product bank
`timescale 1ns/100ps
`default_nettype none

module mcm_coeff_bank #(
	parameter int DATA_W = 17,
	parameter int PROD_W = 25
) (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	// shared terms from the first stage
	input  wire logic signed [PROD_W-1:0] i_term_x1,
	input  wire logic signed [PROD_W-1:0] i_term_x9,
	input  wire logic signed [PROD_W-1:0] i_term_x11,
	input  wire logic signed [PROD_W-1:0] i_term_x13,
	// bit 0 r16, 1 r8, 2 r4, 3 a4, 4 dst
	input  wire logic [4:0]               i_term_vld,
	output logic signed [PROD_W-1:0]      o_r16 [mcm_pkg::R16_LANES],
	output logic signed [PROD_W-1:0]      o_r8  [mcm_pkg::R8_LANES],
	output logic signed [PROD_W-1:0]      o_r4  [mcm_pkg::R4_LANES],
	output logic signed [PROD_W-1:0]      o_a4  [mcm_pkg::A4_LANES],
	output logic signed [PROD_W-1:0]      o_dst [mcm_pkg::DST_LANES]
);

	// largest coefficient is 90, so products need 7 bits over the sample
	if (PROD_W < DATA_W + 7)
	begin : g_width_check
		$error("mcm_coeff_bank: PROD_W too narrow for DATA_W");
	end

	// plain shifts of the sample
	logic signed [PROD_W-1:0] x2;
	logic signed [PROD_W-1:0] x4;
	logic signed [PROD_W-1:0] x8;
	logic signed [PROD_W-1:0] x16;
	logic signed [PROD_W-1:0] x32;
	logic signed [PROD_W-1:0] x64;

	// intermediate products reused inside the 16-point group
	logic signed [PROD_W-1:0] x38;
	logic signed [PROD_W-1:0] x67;
	logic signed [PROD_W-1:0] x88;

	// unregistered products per group
	logic signed [PROD_W-1:0] r16_c [mcm_pkg::R16_LANES];
	logic signed [PROD_W-1:0] r8_c  [mcm_pkg::R8_LANES];
	logic signed [PROD_W-1:0] r4_c  [mcm_pkg::R4_LANES];
	logic signed [PROD_W-1:0] a4_c  [mcm_pkg::A4_LANES];
	logic signed [PROD_W-1:0] dst_c [mcm_pkg::DST_LANES];

	assign x2  = i_term_x1 <<< 1;
	assign x4  = i_term_x1 <<< 2;
	assign x8  = i_term_x1 <<< 3;
	assign x16 = i_term_x1 <<< 4;
	assign x32 = i_term_x1 <<< 5;
	assign x64 = i_term_x1 <<< 6;

	// 38 = 4*9 + 2
	assign x38 = (i_term_x9 <<< 2) + x2;
	// 67 = 2*38 - 9
	assign x67 = (x38 <<< 1) - i_term_x9;
	assign x88 = i_term_x11 <<< 3;

	// 16-point odd rows
	assign r16_c[0]  = x4;
	assign r16_c[1]  = i_term_x13;
	assign r16_c[2]  = i_term_x11 <<< 1;
	assign r16_c[3]  = x32 - i_term_x1;
	assign r16_c[4]  = x38;
	assign r16_c[5]  = (i_term_x11 <<< 2) + x2;
	assign r16_c[6]  = (i_term_x13 <<< 2) + x2;
	assign r16_c[7]  = (i_term_x13 <<< 2) + i_term_x9;
	assign r16_c[8]  = x67;
	assign r16_c[9]  = (i_term_x9 <<< 3) + i_term_x1;
	// 78 = 67 + 11
	assign r16_c[10] = x67 + i_term_x11;
	// 82 = 38 + 4*11
	assign r16_c[11] = x38 + (i_term_x11 <<< 2);
	// 85 reuses the DST 84 product
	assign r16_c[12] = dst_c[3] + i_term_x1;
	assign r16_c[13] = x88;
	assign r16_c[14] = x88 + x2;

	// 8-point odd rows
	assign r8_c[0] = i_term_x9;
	assign r8_c[1] = (i_term_x13 <<< 1) - i_term_x1;
	assign r8_c[2] = (i_term_x11 <<< 2) - i_term_x1;
	// 57 = 61 - 4
	assign r8_c[3] = r16_c[7] - x4;
	assign r8_c[4] = (i_term_x9 <<< 3) - x2;
	assign r8_c[5] = (i_term_x9 <<< 3) + x8;
	assign r8_c[6] = (i_term_x11 <<< 3) - i_term_x1;
	assign r8_c[7] = (i_term_x11 <<< 3) + x2;

	// 4-point odd rows
	assign r4_c[0] = (i_term_x11 <<< 3) + i_term_x1;
	assign r4_c[1] = x64 + i_term_x11;
	// 50 = 2*25
	assign r4_c[2] = r8_c[1] <<< 1;
	assign r4_c[3] = i_term_x9 <<< 1;

	// 4-point even rows
	assign a4_c[0] = x64;
	assign a4_c[1] = (i_term_x9 <<< 3) + i_term_x11;
	assign a4_c[2] = i_term_x9 <<< 2;

	// 4-point DST
	assign dst_c[0] = x16 + i_term_x13;
	assign dst_c[1] = (i_term_x11 <<< 2) + i_term_x11;
	assign dst_c[2] = (i_term_x9 <<< 3) + x2;
	assign dst_c[3] = (i_term_x11 <<< 3) - x4;

	// 16-point group clears when its valid is low
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_r16 <= '{default: '0};
		else if (i_term_vld[0])
			o_r16 <= r16_c;
		else
			o_r16 <= '{default: '0};
	end

	// remaining groups hold their last products
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_r8 <= '{default: '0};
		else if (i_term_vld[1])
			o_r8 <= r8_c;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_r4 <= '{default: '0};
		else if (i_term_vld[2])
			o_r4 <= r4_c;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_a4 <= '{default: '0};
		else if (i_term_vld[3])
			o_a4 <= a4_c;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_dst <= '{default: '0};
		else if (i_term_vld[4])
			o_dst <= dst_c;
	end

endmodule

`default_nettype wire

//--- logic/mcm_pkg.sv
// Coefficient lane counts
`default_nettype none

package mcm_pkg;

	// lane counts per coefficient group
	// each group's output array is indexed in table order

	// 16-point odd rows
	// 4 13 22 31 38 46 54 61 67 73 78 82 85 88 90
	localparam int R16_LANES = 15;

	// 8-point odd rows
	// 9 25 43 57 70 80 87 90
	localparam int R8_LANES = 8;

	// 4-point odd rows, 89 75 50 18
	localparam int R4_LANES = 4;

	// 4-point even rows, 64 83 36
	localparam int A4_LANES = 3;

	// 4-point DST, 29 55 74 84
	localparam int DST_LANES = 4;

endpackage

`default_nettype wire

//--- logic/mcm_top.sv
// Multiplierless constant multiplier top
`timescale 1ns/100ps
`default_nettype none

module mcm_top #(
	// sample width
	parameter int DATA_W = 17,
	// product width, 7 bits of headroom over the sample
	parameter int PROD_W = 25
) (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	// residual sample
	input  wire logic signed [DATA_W-1:0] i_data,
	// one valid per coefficient group
	input  wire logic                     i_vld_r16,
	input  wire logic                     i_vld_r8,
	input  wire logic                     i_vld_r4,
	input  wire logic                     i_vld_a4,
	input  wire logic                     i_vld_dst,
	// products, two cycles after the sample
	output logic signed [PROD_W-1:0]      o_r16 [mcm_pkg::R16_LANES],
	output logic signed [PROD_W-1:0]      o_r8  [mcm_pkg::R8_LANES],
	output logic signed [PROD_W-1:0]      o_r4  [mcm_pkg::R4_LANES],
	output logic signed [PROD_W-1:0]      o_a4  [mcm_pkg::A4_LANES],
	output logic signed [PROD_W-1:0]      o_dst [mcm_pkg::DST_LANES]
);

	// shared partial products, registered
	logic signed [PROD_W-1:0] term_x1;
	logic signed [PROD_W-1:0] term_x9;
	logic signed [PROD_W-1:0] term_x11;
	logic signed [PROD_W-1:0] term_x13;

	// group valids, aligned with the terms
	// bit 0 r16, 1 r8, 2 r4, 3 a4, 4 dst
	logic [4:0] term_vld;

	// first stage
	// sign extension and the x1 x9 x11 x13 terms
	mcm_base_terms #(
		.DATA_W      (DATA_W),
		.PROD_W      (PROD_W)
	) u_base_terms (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_data      (i_data),
		.i_vld_r16   (i_vld_r16),
		.i_vld_r8    (i_vld_r8),
		.i_vld_r4    (i_vld_r4),
		.i_vld_a4    (i_vld_a4),
		.i_vld_dst   (i_vld_dst),
		.o_term_x1   (term_x1),
		.o_term_x9   (term_x9),
		.o_term_x11  (term_x11),
		.o_term_x13  (term_x13),
		.o_term_vld  (term_vld)
	);

	// second stage
	// all 34 products with per-group output registers
	mcm_coeff_bank #(
		.DATA_W      (DATA_W),
		.PROD_W      (PROD_W)
	) u_coeff_bank (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_term_x1   (term_x1),
		.i_term_x9   (term_x9),
		.i_term_x11  (term_x11),
		.i_term_x13  (term_x13),
		.i_term_vld  (term_vld),
		.o_r16       (o_r16),
		.o_r8        (o_r8),
		.o_r4        (o_r4),
		.o_a4        (o_a4),
		.o_dst       (o_dst)
	);

endmodule

`default_nettype wire

//--- sim/mcm_properties.sv
// Output gating assertions
`timescale 1ns/100ps
`default_nettype none

module mcm_properties #(
	parameter int PROD_W = 25
) (
	input wire logic                     clk,
	input wire logic                     rst_n,
	input wire logic                     i_vld_r16,
	input wire logic                     i_vld_r8,
	input wire logic signed [PROD_W-1:0] o_r16 [mcm_pkg::R16_LANES],
	input wire logic signed [PROD_W-1:0] o_r8  [mcm_pkg::R8_LANES],
	input wire logic signed [PROD_W-1:0] o_r4  [mcm_pkg::R4_LANES],
	input wire logic signed [PROD_W-1:0] o_a4  [mcm_pkg::A4_LANES],
	input wire logic signed [PROD_W-1:0] o_dst [mcm_pkg::DST_LANES]
);

	// flat copies of the output arrays
	logic [mcm_pkg::R16_LANES*PROD_W-1:0] r16_flat;
	logic [mcm_pkg::R8_LANES*PROD_W-1:0]  r8_flat;
	logic [mcm_pkg::R4_LANES*PROD_W-1:0]  r4_flat;
	logic [mcm_pkg::A4_LANES*PROD_W-1:0]  a4_flat;
	logic [mcm_pkg::DST_LANES*PROD_W-1:0] dst_flat;

	// running count of failed assertions
	int n_fail = 0;

	for (genvar i = 0; i < mcm_pkg::R16_LANES; i++)
	begin : g_r16
		assign r16_flat[i*PROD_W +: PROD_W] = o_r16[i];
	end
	for (genvar i = 0; i < mcm_pkg::R8_LANES; i++)
	begin : g_r8
		assign r8_flat[i*PROD_W +: PROD_W] = o_r8[i];
	end
	for (genvar i = 0; i < mcm_pkg::R4_LANES; i++)
	begin : g_r4
		assign r4_flat[i*PROD_W +: PROD_W] = o_r4[i];
	end
	for (genvar i = 0; i < mcm_pkg::A4_LANES; i++)
	begin : g_a4
		assign a4_flat[i*PROD_W +: PROD_W] = o_a4[i];
	end
	for (genvar i = 0; i < mcm_pkg::DST_LANES; i++)
	begin : g_dst
		assign dst_flat[i*PROD_W +: PROD_W] = o_dst[i];
	end

	// idle 16-point cycle clears that group two edges later
	a_r16_clears : assert property (@(posedge clk) disable iff (!rst_n)
		!i_vld_r16 |-> ##2 (r16_flat == '0))
	else
	begin
		$error("o_r16 not zero two cycles after i_vld_r16 low");
		n_fail++;
	end

	// idle 8-point cycle leaves that group untouched
	a_r8_holds : assert property (@(posedge clk) disable iff (!rst_n)
		!i_vld_r8 |-> ##2 $stable(r8_flat))
	else
	begin
		$error("o_r8 changed two cycles after i_vld_r8 low");
		n_fail++;
	end

	// every output bit is known once reset is released
	a_no_unknown : assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({r16_flat, r8_flat, r4_flat, a4_flat, dst_flat}))
	else
	begin
		$error("unknown bits on the product outputs");
		n_fail++;
	end

endmodule

bind mcm_top mcm_properties #(
	.PROD_W    (PROD_W)
) u_properties (
	.clk       (clk),
	.rst_n     (rst_n),
	.i_vld_r16 (i_vld_r16),
	.i_vld_r8  (i_vld_r8),
	.o_r16     (o_r16),
	.o_r8      (o_r8),
	.o_r4      (o_r4),
	.o_a4      (o_a4),
	.o_dst     (o_dst)
);

`default_nettype wire

//--- sim/mcm_tb.sv
// Constant multiplier testbench
`timescale 1ns/100ps
`default_nettype none

module mcm_tb;

	localparam int DATA_W = 17;
	localparam int PROD_W = 25;
	localparam int SEED   = 97437;
	localparam int N_ROWS = 20;
	localparam int N_RAND = 300;
	// tests run for about 390 cycles
	localparam int MAX_CYCLES = 2000;

	// coefficient values in lane order
	localparam int R16_COEF [mcm_pkg::R16_LANES] =
		'{4, 13, 22, 31, 38, 46, 54, 61, 67, 73, 78, 82, 85, 88, 90};
	localparam int R8_COEF [mcm_pkg::R8_LANES] = '{9, 25, 43, 57, 70, 80, 87, 90};
	localparam int R4_COEF [mcm_pkg::R4_LANES] = '{89, 75, 50, 18};
	localparam int A4_COEF [mcm_pkg::A4_LANES] = '{64, 83, 36};
	localparam int DST_COEF [mcm_pkg::DST_LANES] = '{29, 55, 74, 84};

	// stimulus table with one row per sample
	// ROW_DATA sample, ROW_VLD valids {dst a4 r4 r8 r16}, ROW_X90 expected o_r16[14]
	localparam int ROW_DATA [N_ROWS] = '{
		0, 1, -1, 65535, -65536, 12345, -7,
		100, -200, 300, -400, 500,
		777, -777, 32767, -32768, 2, -65535, 4095, -12345};
	localparam logic [4:0] ROW_VLD [N_ROWS] = '{
		5'b11111, 5'b11111, 5'b11111, 5'b11111, 5'b11111, 5'b11111, 5'b11111,
		5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b10000,
		5'b00011, 5'b11100, 5'b10101, 5'b01010, 5'b11111, 5'b00001, 5'b11110, 5'b11111};
	localparam int ROW_X90 [N_ROWS] = '{
		0, 90, -90, 5898150, -5898240, 1111050, -630,
		9000, 0, 0, 0, 0,
		69930, 0, 2949030, 0, 180, -5898150, 0, -1111050};

	logic clk;
	logic rst_n;
	logic signed [DATA_W-1:0] i_data;
	logic i_vld_r16;
	logic i_vld_r8;
	logic i_vld_r4;
	logic i_vld_a4;
	logic i_vld_dst;
	logic signed [PROD_W-1:0] o_r16 [mcm_pkg::R16_LANES];
	logic signed [PROD_W-1:0] o_r8  [mcm_pkg::R8_LANES];
	logic signed [PROD_W-1:0] o_r4  [mcm_pkg::R4_LANES];
	logic signed [PROD_W-1:0] o_a4  [mcm_pkg::A4_LANES];
	logic signed [PROD_W-1:0] o_dst [mcm_pkg::DST_LANES];

	// model shadow of what each output should read now
	logic [PROD_W-1:0] exp_r16 [mcm_pkg::R16_LANES];
	logic [PROD_W-1:0] exp_r8  [mcm_pkg::R8_LANES];
	logic [PROD_W-1:0] exp_r4  [mcm_pkg::R4_LANES];
	logic [PROD_W-1:0] exp_a4  [mcm_pkg::A4_LANES];
	logic [PROD_W-1:0] exp_dst [mcm_pkg::DST_LANES];

	// inputs still in the pipe
	// index 0 driven last cycle and 1 the cycle before
	int pend_data [2];
	logic [4:0] pend_vld [2];

	int check_count = 0;
	int error_count = 0;
	int test_count  = 0;
	int test_fails  = 0;
	int test_start  = 0;

	tb_clock #(.PERIOD_NS(10), .RESET_CYCLES(5)) u_clock (.clk(clk), .rst_n(rst_n));

	mcm_top #(.DATA_W(DATA_W), .PROD_W(PROD_W)) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_data    (i_data),
		.i_vld_r16 (i_vld_r16),
		.i_vld_r8  (i_vld_r8),
		.i_vld_r4  (i_vld_r4),
		.i_vld_a4  (i_vld_a4),
		.i_vld_dst (i_vld_dst),
		.o_r16     (o_r16),
		.o_r8      (o_r8),
		.o_r4      (o_r4),
		.o_a4      (o_a4),
		.o_dst     (o_dst)
	);

	// sample times coefficient cut to product width
	function automatic logic [PROD_W-1:0] product(input int sample, input int coef);
		return PROD_W'(sample * coef);
	endfunction

	// any value in the signed sample range
	function automatic int random_sample();
		return int'($urandom_range(131071)) - 65536;
	endfunction

	task automatic check_value(input string name, input logic [PROD_W-1:0] expected,
		input logic [PROD_W-1:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected %0d actual %0d",
				$time, name, $signed(expected), $signed(actual));
		end
	endtask

	// one sample reaching the output registers
	task automatic update_model(input int data, input logic [4:0] vld);
		// 16-point lanes clear without a valid
		for (int i = 0; i < mcm_pkg::R16_LANES; i++)
			exp_r16[i] = vld[0] ? product(data, R16_COEF[i]) : '0;
		// the rest only load on a valid
		if (vld[1])
			for (int i = 0; i < mcm_pkg::R8_LANES; i++)
				exp_r8[i] = product(data, R8_COEF[i]);
		if (vld[2])
			for (int i = 0; i < mcm_pkg::R4_LANES; i++)
				exp_r4[i] = product(data, R4_COEF[i]);
		if (vld[3])
			for (int i = 0; i < mcm_pkg::A4_LANES; i++)
				exp_a4[i] = product(data, A4_COEF[i]);
		if (vld[4])
			for (int i = 0; i < mcm_pkg::DST_LANES; i++)
				exp_dst[i] = product(data, DST_COEF[i]);
	endtask

	task automatic check_outputs();
		for (int i = 0; i < mcm_pkg::R16_LANES; i++)
			check_value($sformatf("o_r16[%0d]", i), exp_r16[i], o_r16[i]);
		for (int i = 0; i < mcm_pkg::R8_LANES; i++)
			check_value($sformatf("o_r8[%0d]", i), exp_r8[i], o_r8[i]);
		for (int i = 0; i < mcm_pkg::R4_LANES; i++)
			check_value($sformatf("o_r4[%0d]", i), exp_r4[i], o_r4[i]);
		for (int i = 0; i < mcm_pkg::A4_LANES; i++)
			check_value($sformatf("o_a4[%0d]", i), exp_a4[i], o_a4[i]);
		for (int i = 0; i < mcm_pkg::DST_LANES; i++)
			check_value($sformatf("o_dst[%0d]", i), exp_dst[i], o_dst[i]);
	endtask

	// one clock that checks what arrived and then drives the next sample
	task automatic run_cycle(input int data, input logic [4:0] vld);
		@(posedge clk);
		#1;
		// outputs now reflect the sample driven two cycles back
		update_model(pend_data[1], pend_vld[1]);
		check_outputs();
		pend_data[1] = pend_data[0];
		pend_vld[1]  = pend_vld[0];
		pend_data[0] = data;
		pend_vld[0]  = vld;
		i_data    = DATA_W'(data);
		i_vld_r16 = vld[0];
		i_vld_r8  = vld[1];
		i_vld_r4  = vld[2];
		i_vld_a4  = vld[3];
		i_vld_dst = vld[4];
	endtask

	// each row is one sample and three idle cycles with junk data
	task automatic run_rows(input int first, input int last);
		for (int r = first; r <= last; r++)
		begin
			run_cycle(ROW_DATA[r], ROW_VLD[r]);
			run_cycle(random_sample(), 5'b00000);
			run_cycle(random_sample(), 5'b00000);
			check_value($sformatf("o_r16[14] row %0d", r), PROD_W'(ROW_X90[r]), o_r16[14]);
			run_cycle(random_sample(), 5'b00000);
		end
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (error_count == test_start)
			$display("test %0d %s: pass", test_count, name);
		else
		begin
			test_fails++;
			$display("test %0d %s: fail, %0d mismatches", test_count, name,
				error_count - test_start);
		end
		test_start = error_count;
	endtask

	initial
	begin : watchdog
		int cycles;
		for (cycles = 0; cycles < MAX_CYCLES; cycles++)
			@(posedge clk);
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(SEED));
		i_data    = '0;
		i_vld_r16 = 1'b0;
		i_vld_r8  = 1'b0;
		i_vld_r4  = 1'b0;
		i_vld_a4  = 1'b0;
		i_vld_dst = 1'b0;
		for (int i = 0; i < 2; i++)
		begin
			pend_data[i] = 0;
			pend_vld[i]  = 5'b00000;
		end
		// reset state of the outputs
		update_model(0, 5'b00000);
		for (int i = 0; i < mcm_pkg::R8_LANES; i++)
			exp_r8[i] = '0;
		for (int i = 0; i < mcm_pkg::R4_LANES; i++)
			exp_r4[i] = '0;
		for (int i = 0; i < mcm_pkg::A4_LANES; i++)
			exp_a4[i] = '0;
		for (int i = 0; i < mcm_pkg::DST_LANES; i++)
			exp_dst[i] = '0;
		wait (rst_n);

		repeat (3) run_cycle(random_sample(), 5'b00000);
		report_test("zero after reset");
		run_rows(0, 6);
		report_test("all groups valid");
		run_rows(7, 11);
		report_test("single group valid");
		run_rows(12, N_ROWS - 1);
		report_test("mixed valids and idle hold");

		// back to back with two samples always in the pipe
		for (int n = 0; n < N_RAND; n++)
			run_cycle(random_sample(), 5'($urandom));
		repeat (2) run_cycle(random_sample(), 5'b00000);
		report_test("random stream");

		check_value("assertion failures", '0, PROD_W'(UUT.u_properties.n_fail));
		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			test_count, test_fails, check_count, error_count);
		if (error_count == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	// free-running clock, first rising edge at half a period
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset low for the first cycles, released just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire
